/* Makefile */
SIM      = verilator
TOP      = matmul_tb
FILELIST = filelist.f
FLAGS    = --binary --timing -Wno-fatal --top-module $(TOP)
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^NO ERRORS$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* filelist.f */
hdl/matmul_pkg.sv
hdl/buf_if.sv
hdl/operand_buffer.sv
hdl/dma_reader.sv
hdl/mm_core.sv
hdl/result_writer.sv
hdl/matmul_top.sv
verif/matmul_tb.sv

/* hdl/buf_if.sv */
// ****************************************
// write and read ports of one operand buffer
// reader writes, buffer stores, core reads
// ****************************************
`timescale 1ns/10ps

interface buf_if
    import matmul_pkg::*;
();

    // line write from the reader
    logic               wr_en;
    logic [LINE_AW-1:0] wr_addr;
    buf_line_u          wr_data;
    // line read by the core, data one cycle after address
    logic [LINE_AW-1:0] rd_addr;
    buf_line_u          rd_data;

    modport writer   (output wr_en, output wr_addr, output wr_data);
    modport storage  (input wr_en, input wr_addr, input wr_data, input rd_addr, output rd_data);
    modport consumer (output rd_addr, input rd_data);

endinterface

/* hdl/dma_reader.sv */
// ****************************************
// input side: fetches A and B element by element, interleaved,
// packs rows into lines for the two operand buffers
// and kicks the multiply core once both are loaded
// ****************************************
`timescale 1ns/10ps

module dma_reader
    import matmul_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              start_i,
    input  logic [ADDR_W-1:0] a_base_i,
    input  logic [ADDR_W-1:0] b_base_i,
    // request port
    output logic              rd_req_valid_o,
    input  logic              rd_req_ready_i,
    output logic [ADDR_W-1:0] rd_req_addr_o,
    output id_e               rd_req_id_o,
    // response port
    input  logic              rd_rsp_valid_i,
    output logic              rd_rsp_ready_o,
    input  elem_t             rd_rsp_data_i,
    input  id_e               rd_rsp_id_i,
    // operand buffers
    buf_if.writer             buf_a,
    buf_if.writer             buf_b,
    output logic              mm_start_o
);

    logic                   busy_q;
    logic                   start_ok;
    logic [ADDR_W-1:0]      a_base_q;
    logic [ADDR_W-1:0]      b_base_q;
    // bit 0 picks A or B, upper bits are the element index r*4+c
    logic [2*LINE_AW:0]     req_cnt_q;
    logic                   req_valid_q;
    logic                   rsp_fire;
    // per id packing state, indexed by id_e
    buf_line_u              pack_q     [2];
    // elements per line equal lines per matrix, so same width
    logic [LINE_AW-1:0]     elem_cnt_q [2];
    logic [LINE_AW-1:0]     line_cnt_q [2];
    logic [1:0]             wr_en_q;
    logic [1:0]             full_q;
    logic [1:0]             line_last;
    logic [1:0]             full_now;

    assign start_ok = start_i && !busy_q;

    // request side
    assign rd_req_valid_o = req_valid_q;
    assign rd_req_id_o    = id_e'(req_cnt_q[0]);
    assign rd_req_addr_o  = (req_cnt_q[0] ? b_base_q : a_base_q)
                          + ADDR_W'(req_cnt_q[2*LINE_AW:1]);

    // buffers always have room, never stall responses
    assign rd_rsp_ready_o = 1'b1;
    assign rsp_fire       = rd_rsp_valid_i && rd_rsp_ready_o;

    // last line of a matrix being written this cycle
    always_comb begin
        for (int i = 0; i < 2; i++) begin
            line_last[i] = wr_en_q[i] && (line_cnt_q[i] == LINE_AW'(MAT_N-1));
            full_now[i]  = full_q[i] || line_last[i];
        end
    end

    // bases are held for the whole load
    always_ff @(posedge clk) begin
        if (start_ok) begin
            a_base_q <= a_base_i;
            b_base_q <= b_base_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy_q      <= 1'b0;
            req_valid_q <= 1'b0;
            req_cnt_q   <= '0;
            mm_start_o  <= 1'b0;
            wr_en_q     <= '0;
            full_q      <= '0;
            for (int i = 0; i < 2; i++) begin
                elem_cnt_q[i] <= '0;
                line_cnt_q[i] <= '0;
            end
        end else if (start_ok) begin
            busy_q      <= 1'b1;
            req_valid_q <= 1'b1;
            req_cnt_q   <= '0;
            mm_start_o  <= 1'b0;
            wr_en_q     <= '0;
            full_q      <= '0;
            for (int i = 0; i < 2; i++) begin
                elem_cnt_q[i] <= '0;
                line_cnt_q[i] <= '0;
            end
        end else begin
            // step to the next request only on handshake
            if (rd_req_valid_o && rd_req_ready_i) begin
                req_cnt_q <= req_cnt_q + 1'b1;
                if (&req_cnt_q)
                    req_valid_q <= 1'b0;
            end
            for (int i = 0; i < 2; i++) begin
                wr_en_q[i] <= 1'b0;
                if (rsp_fire && rd_rsp_id_i == id_e'(i)) begin
                    elem_cnt_q[i] <= elem_cnt_q[i] + 1'b1;
                    // fourth element done, write line next cycle
                    wr_en_q[i]    <= (elem_cnt_q[i] == LINE_AW'(MAT_N-1));
                end
                if (wr_en_q[i]) begin
                    line_cnt_q[i] <= line_cnt_q[i] + 1'b1;
                    full_q[i]     <= full_now[i];
                end
            end
            // second matrix finished, one pulse to the core
            mm_start_o <= busy_q && (&full_now) && (|line_last);
            if (busy_q && (&full_now) && (|line_last))
                busy_q <= 1'b0;
        end
    end

    // shift in from the top, column 0 ends up in the low slot
    always_ff @(posedge clk) begin
        for (int i = 0; i < 2; i++) begin
            if (rsp_fire && rd_rsp_id_i == id_e'(i))
                pack_q[i].raw <= {rd_rsp_data_i, pack_q[i].raw[MAT_N*ELEM_W-1:ELEM_W]};
        end
    end

    assign buf_a.wr_en   = wr_en_q[ID_A];
    assign buf_a.wr_addr = line_cnt_q[ID_A];
    assign buf_a.wr_data = pack_q[ID_A];
    assign buf_b.wr_en   = wr_en_q[ID_B];
    assign buf_b.wr_addr = line_cnt_q[ID_B];
    assign buf_b.wr_data = pack_q[ID_B];

endmodule

/* hdl/matmul_pkg.sv */
// ****************************************
// shared sizes and types for the 4x4 matrix multiply accelerator
// imported by every RTL block and by the testbench
// ****************************************

package matmul_pkg;

    // fixed problem size
    localparam int MAT_N   = 4;
    localparam int ELEM_W  = 16;
    localparam int ACC_W   = 32;
    // element address on the memory side
    localparam int ADDR_W  = 16;
    // index of a line inside an operand buffer
    localparam int LINE_AW = 2;

    typedef logic signed [ELEM_W-1:0] elem_t;
    // results wrap modulo 2^32
    typedef logic signed [ACC_W-1:0] acc_t;

    // one buffer line holds a full matrix row
    // reader fills it as a raw word, core picks elements out of it
    typedef union packed {
        logic [MAT_N*ELEM_W-1:0] raw;
        elem_t [MAT_N-1:0]       elem;   // elem[0] is column 0
    } buf_line_u;

    // accumulator array, [row][column]
    typedef acc_t [MAT_N-1:0][MAT_N-1:0] acc_mat_t;

    // request tag, tells A traffic from B traffic
    typedef enum logic {
        ID_A = 1'b0,
        ID_B = 1'b1
    } id_e;

endpackage

/* hdl/matmul_top.sv */
// ****************************************
// accelerator top: reader, two operand buffers, core and writer
// memory request/response and result stream on plain ports
// ****************************************
`timescale 1ns/10ps

module matmul_top
    import matmul_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              start_i,
    input  logic [ADDR_W-1:0] a_base_i,
    input  logic [ADDR_W-1:0] b_base_i,
    // memory requests
    output logic              rd_req_valid_o,
    input  logic              rd_req_ready_i,
    output logic [ADDR_W-1:0] rd_req_addr_o,
    output id_e               rd_req_id_o,
    // memory responses
    input  logic              rd_rsp_valid_i,
    output logic              rd_rsp_ready_o,
    input  elem_t             rd_rsp_data_i,
    input  id_e               rd_rsp_id_i,
    // result stream
    output logic              res_valid_o,
    input  logic              res_ready_i,
    output acc_t              res_data_o,
    output logic              res_last_o,
    output logic              done_o
);

    logic     run_q;
    logic     start_ok;
    logic     mm_start;
    logic     mm_done;
    acc_mat_t acc;

    buf_if buf_a_if ();
    buf_if buf_b_if ();

    // a run lasts from accepted start to done, starts in between are dropped
    assign start_ok = start_i && !run_q;

    always_ff @(posedge clk) begin
        if (!rst_n)
            run_q <= 1'b0;
        else if (start_ok)
            run_q <= 1'b1;
        else if (done_o)
            run_q <= 1'b0;
    end

    dma_reader dma_reader_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .start_i        (start_ok),
        .a_base_i       (a_base_i),
        .b_base_i       (b_base_i),
        .rd_req_valid_o (rd_req_valid_o),
        .rd_req_ready_i (rd_req_ready_i),
        .rd_req_addr_o  (rd_req_addr_o),
        .rd_req_id_o    (rd_req_id_o),
        .rd_rsp_valid_i (rd_rsp_valid_i),
        .rd_rsp_ready_o (rd_rsp_ready_o),
        .rd_rsp_data_i  (rd_rsp_data_i),
        .rd_rsp_id_i    (rd_rsp_id_i),
        .buf_a          (buf_a_if),
        .buf_b          (buf_b_if),
        .mm_start_o     (mm_start)
    );

    operand_buffer buf_a_i (.clk (clk), .bus (buf_a_if));
    operand_buffer buf_b_i (.clk (clk), .bus (buf_b_if));

    mm_core mm_core_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .start_i (mm_start),
        .buf_a   (buf_a_if),
        .buf_b   (buf_b_if),
        .acc_o   (acc),
        .done_o  (mm_done)
    );

    result_writer result_writer_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .start_i     (mm_done),
        .acc_i       (acc),
        .res_valid_o (res_valid_o),
        .res_ready_i (res_ready_i),
        .res_data_o  (res_data_o),
        .res_last_o  (res_last_o),
        .done_o      (done_o)
    );

endmodule

/* hdl/mm_core.sv */
// ****************************************
// multiply core: walks (i, k) over the A and B lines
// and does four MACs per cycle into the 4x4 accumulators
// ****************************************
`timescale 1ns/10ps

module mm_core
    import matmul_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     start_i,
    buf_if.consumer  buf_a,
    buf_if.consumer  buf_b,
    output acc_mat_t acc_o,
    output logic     done_o
);

    logic                 run_q;
    // upper half is row i of A, lower half is k
    logic [2*LINE_AW-1:0] step_q;
    // MAC stage, one cycle behind the read address
    logic                 mac_q;
    logic [LINE_AW-1:0]   mac_i_q;
    logic [LINE_AW-1:0]   mac_k_q;
    acc_mat_t             acc_q;
    elem_t                a_elem;
    acc_t                 prod [MAT_N];

    // A line i and B line k
    assign buf_a.rd_addr = step_q[2*LINE_AW-1:LINE_AW];
    assign buf_b.rd_addr = step_q[LINE_AW-1:0];

    assign acc_o = acc_q;

    // sequencer
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            run_q  <= 1'b0;
            step_q <= '0;
            mac_q  <= 1'b0;
            done_o <= 1'b0;
        end else if (start_i) begin
            run_q  <= 1'b1;
            step_q <= '0;
            mac_q  <= 1'b0;
            done_o <= 1'b0;
        end else begin
            mac_q <= run_q;
            if (run_q) begin
                step_q <= step_q + 1'b1;
                if (&step_q)
                    run_q <= 1'b0;
            end
            // last MAC lands this edge, result valid next cycle
            done_o <= mac_q && (&mac_i_q) && (&mac_k_q);
        end
    end

    // A[i][k] times the whole B row k
    always_comb begin
        a_elem = buf_a.rd_data.elem[mac_k_q];
        for (int j = 0; j < MAT_N; j++) begin
            prod[j] = acc_t'(a_elem) * acc_t'(buf_b.rd_data.elem[j]);
        end
    end

    // accumulator row i gets four products per cycle
    always_ff @(posedge clk) begin
        mac_i_q <= buf_a.rd_addr;
        mac_k_q <= buf_b.rd_addr;
        if (start_i) begin
            acc_q <= '0;
        end else if (mac_q) begin
            for (int j = 0; j < MAT_N; j++) begin
                // wraps mod 2^32
                acc_q[mac_i_q][j] <= acc_q[mac_i_q][j] + prod[j];
            end
        end
    end

endmodule

/* hdl/operand_buffer.sv */
// ****************************************
// four-line operand store, one write port and a registered read
// used once for A and once for B
// ****************************************
`timescale 1ns/10ps

module operand_buffer
    import matmul_pkg::*;
(
    input  logic  clk,
    buf_if.storage bus
);

    // one line per matrix row
    buf_line_u mem_q [MAT_N];

    // whole line writes only
    always_ff @(posedge clk) begin
        if (bus.wr_en)
            mem_q[bus.wr_addr] <= bus.wr_data;
    end

    // read data follows the address by one cycle
    always_ff @(posedge clk) begin
        bus.rd_data <= mem_q[bus.rd_addr];
    end

endmodule

/* hdl/result_writer.sv */
// ****************************************
// output side: streams the 16 results row-major over valid/ready,
// flags the last word, then pulses done
// ****************************************
`timescale 1ns/10ps

module result_writer
    import matmul_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     start_i,
    input  acc_mat_t acc_i,
    output logic     res_valid_o,
    input  logic     res_ready_i,
    output acc_t     res_data_o,
    output logic     res_last_o,
    output logic     done_o
);

    // word k is C[k/4][k%4]
    logic [2*LINE_AW-1:0] idx_q;
    logic                 valid_q;

    assign res_valid_o = valid_q;
    // accumulators stay put until the next run, so the word holds
    assign res_data_o  = acc_i[idx_q[2*LINE_AW-1:LINE_AW]][idx_q[LINE_AW-1:0]];
    assign res_last_o  = valid_q && (&idx_q);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
            idx_q   <= '0;
            done_o  <= 1'b0;
        end else begin
            done_o <= 1'b0;
            if (start_i) begin
                valid_q <= 1'b1;
                idx_q   <= '0;
            end else if (valid_q && res_ready_i) begin
                idx_q <= idx_q + 1'b1;
                // last word taken
                if (&idx_q) begin
                    valid_q <= 1'b0;
                    done_o  <= 1'b1;
                end
            end
        end
    end

endmodule

/* verif/matmul_golden.txt */
# per test: a_base b_base, then A rows 0-3 and B rows 0-3 as 16-bit hex, column 0 first
# then the expected C rows 0-3 as 32-bit hex, column 0 first
0100 0200
0001 0002 0003 0004
0005 0006 0007 0008
0009 000a 000b 000c
000d 000e 000f 0010
0001 0000 0000 0001
0000 0001 0001 0000
0002 0000 0000 0002
0000 0003 0003 0000
00000007 0000000e 0000000e 00000007
00000013 0000001e 0000001e 00000013
0000001f 0000002e 0000002e 0000001f
0000002b 0000003e 0000003e 0000002b
1000 0ff0
8000 8000 8000 8000
ffff 0002 0000 0001
7fff 0000 0000 0000
0003 fffe 0004 0000
8000 0001 0002 ffff
8000 0003 0000 0001
8000 fffd 0005 0000
8000 0000 0001 0002
00000000 ffff8000 fffc0000 ffff0000
ffff0000 00000005 ffffffff 00000005
c0008000 00007fff 0000fffe ffff8001
fffd8000 fffffff1 0000001a fffffffb

/* verif/matmul_tb.sv */
// ****************************************
// testbench for the matrix multiply accelerator
// memory model, back-pressure and golden compare
// data comes from verif/matmul_golden.txt
// ****************************************
`timescale 1ns/10ps

module matmul_tb
    import matmul_pkg::*;
();

    logic              clk;
    logic              rst_n;
    logic              start_i;
    logic [ADDR_W-1:0] a_base_i;
    logic [ADDR_W-1:0] b_base_i;
    logic              rd_req_valid_o;
    logic              rd_req_ready_i;
    logic [ADDR_W-1:0] rd_req_addr_o;
    id_e               rd_req_id_o;
    logic              rd_rsp_valid_i;
    logic              rd_rsp_ready_o;
    elem_t             rd_rsp_data_i;
    id_e               rd_rsp_id_i;
    logic              res_valid_o;
    logic              res_ready_i;
    acc_t              res_data_o;
    logic              res_last_o;
    logic              done_o;

    // golden data with 16 entries per test in row-major order
    logic [ADDR_W-1:0] a_base_q [$];
    logic [ADDR_W-1:0] b_base_q [$];
    elem_t             a_gold [$];
    elem_t             b_gold [$];
    acc_t              c_gold [$];
    int                num_tests;
    // memory model queues that answer in request order
    elem_t             mem [1 << ADDR_W];
    logic [ADDR_W-1:0] q_addr [$];
    id_e               q_id [$];
    int                q_due [$];
    int                last_due;
    integer            seed;
    // scoreboard
    int                errors;
    int                cycle;
    int                cur;
    int                req_cnt;
    int                res_cnt;
    int                done_cnt;
    int                last_hs;
    bit                started;
    bit                loaded;
    int                elem_idx;
    id_e               exp_id;
    logic [ADDR_W-1:0] exp_addr;
    int                due;

    matmul_top matmul_top_i (.*);

    always #4 clk = ~clk;

    task automatic check_acc(input string name, input acc_t exp, input acc_t act);
        if (act !== exp) begin
            $display("[ERROR] %s: expected %h, got %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_addr(input string name, input logic [ADDR_W-1:0] exp,
                              input logic [ADDR_W-1:0] act);
        if (act !== exp) begin
            $display("[ERROR] %s: expected %h, got %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_id(input string name, input id_e exp, input id_e act);
        if (act !== exp) begin
            $display("[ERROR] %s: expected %h, got %h", name, exp, act);
            errors++;
        end
    endtask

    // skips comment and empty lines and returns an empty string at end of file
    task automatic next_line(input int fd, output string line);
        int n;
        line = "";
        while (line == "" && !$feof(fd)) begin
            n = $fgets(line, fd);
            if (n == 0 || line.len() < 2 || line[0] == "#")
                line = "";
        end
    endtask

    task automatic read_row(input int fd, output logic [3:0][31:0] row);
        string       line;
        int          n;
        logic [31:0] e0, e1, e2, e3;
        next_line(fd, line);
        n = $sscanf(line, "%h %h %h %h", e0, e1, e2, e3);
        if (n != 4) begin
            $display("golden file has a row without four values: %s", line);
            errors++;
        end
        row = {e3, e2, e1, e0};
    endtask

    task automatic load_golden();
        int               fd;
        int               n;
        string            line;
        logic [31:0]      ba, bb;
        logic [3:0][31:0] row;
        num_tests = 0;
        fd = $fopen("verif/matmul_golden.txt", "r");
        if (fd == 0) begin
            $display("golden file verif/matmul_golden.txt cannot be opened");
            errors++;
            return;
        end
        next_line(fd, line);
        while (line != "") begin
            n = $sscanf(line, "%h %h", ba, bb);
            if (n != 2) begin
                $display("golden file has a base line without two addresses: %s", line);
                errors++;
            end
            a_base_q.push_back(ba[ADDR_W-1:0]);
            b_base_q.push_back(bb[ADDR_W-1:0]);
            // A rows, then B rows, then C rows
            for (int r = 0; r < 3 * MAT_N; r++) begin
                read_row(fd, row);
                for (int c = 0; c < MAT_N; c++) begin
                    if (r < MAT_N)
                        a_gold.push_back(elem_t'(row[c][ELEM_W-1:0]));
                    else if (r < 2 * MAT_N)
                        b_gold.push_back(elem_t'(row[c][ELEM_W-1:0]));
                    else
                        c_gold.push_back(acc_t'(row[c]));
                end
            end
            num_tests++;
            next_line(fd, line);
        end
        $fclose(fd);
    endtask

    // background pattern from the full address with the operands on top
    task automatic fill_memory();
        logic [ADDR_W-1:0] addr;
        for (int a = 0; a < (1 << ADDR_W); a++) begin
            addr   = ADDR_W'(a);
            mem[a] = elem_t'(addr ^ (addr >> 5) ^ 16'h5a3c);
        end
        for (int t = 0; t < num_tests; t++) begin
            for (int i = 0; i < MAT_N * MAT_N; i++) begin
                addr      = a_base_q[t] + ADDR_W'(i);
                mem[addr] = a_gold[t * 16 + i];
                addr      = b_base_q[t] + ADDR_W'(i);
                mem[addr] = b_gold[t * 16 + i];
            end
        end
    endtask

    // random ready on both ports and a response once its delay is over
    always @(negedge clk) begin
        rd_req_ready_i = ($random(seed) & 3) != 0;
        res_ready_i    = ($random(seed) & 3) != 0;
        if (q_due.size() > 0 && q_due[0] <= cycle) begin
            rd_rsp_valid_i = 1'b1;
            rd_rsp_data_i  = mem[q_addr[0]];
            rd_rsp_id_i    = q_id[0];
        end else begin
            rd_rsp_valid_i = 1'b0;
        end
    end

    // handshakes are taken from values just before the edge
    always @(posedge clk) begin
        if (rst_n) begin
            if (!started && (rd_req_valid_o !== 1'b0 || res_valid_o !== 1'b0
                             || res_last_o !== 1'b0 || done_o !== 1'b0)) begin
                $display("request valid, result valid, last or done high before the first start");
                errors++;
            end
            if (!started && rd_rsp_ready_o !== 1'b1) begin
                $display("response ready not high after reset");
                errors++;
            end
            if (rd_req_valid_o && rd_req_ready_i) begin
                if (req_cnt < 32) begin
                    // even requests fetch A and odd ones B, element r*4+c in turn
                    elem_idx = req_cnt / 2;
                    exp_id   = (req_cnt % 2 == 0) ? ID_A : ID_B;
                    exp_addr = ((exp_id == ID_A) ? a_base_q[cur] : b_base_q[cur])
                             + ADDR_W'(MAT_N * (elem_idx / MAT_N) + elem_idx % MAT_N);
                    check_addr($sformatf("test%0d request %0d", cur, req_cnt),
                               exp_addr, rd_req_addr_o);
                    check_id($sformatf("test%0d request %0d id", cur, req_cnt),
                             exp_id, rd_req_id_o);
                end else begin
                    $display("test%0d: more than 32 requests", cur);
                    errors++;
                end
                req_cnt++;
                due = cycle + 1 + ($random(seed) & 3);
                if (due < last_due)
                    due = last_due;
                last_due = due;
                q_addr.push_back(rd_req_addr_o);
                q_id.push_back(rd_req_id_o);
                q_due.push_back(due);
            end
            if (rd_rsp_valid_i && rd_rsp_ready_o) begin
                void'(q_addr.pop_front());
                void'(q_id.pop_front());
                void'(q_due.pop_front());
            end
            if (done_o) begin
                done_cnt++;
                if (res_cnt != 16 || cycle != last_hs + 1) begin
                    $display("test%0d: done_o not one cycle after the 16th result", cur);
                    errors++;
                end
            end
            if (res_valid_o && res_ready_i) begin
                if (res_cnt < 16) begin
                    check_acc($sformatf("test%0d C[%0d][%0d]", cur, res_cnt / 4, res_cnt % 4),
                              c_gold[cur * 16 + res_cnt], res_data_o);
                    if (res_last_o !== (res_cnt == 15)) begin
                        $display("test%0d: res_last_o wrong on word %0d", cur, res_cnt);
                        errors++;
                    end
                end else begin
                    $display("test%0d: more than 16 results", cur);
                    errors++;
                end
                res_cnt++;
                last_hs = cycle;
            end
        end
        cycle++;
    end

    task automatic run_test(input int t);
        @(negedge clk);
        cur      = t;
        req_cnt  = 0;
        res_cnt  = 0;
        done_cnt = 0;
        a_base_i = a_base_q[t];
        b_base_i = b_base_q[t];
        start_i  = 1'b1;
        started  = 1'b1;
        @(negedge clk);
        start_i = 1'b0;
        // a start while busy has to be dropped
        repeat (4) @(negedge clk);
        a_base_i = 16'hdead;
        b_base_i = 16'hbeef;
        start_i  = 1'b1;
        @(negedge clk);
        start_i = 1'b0;
        while (done_cnt == 0)
            @(negedge clk);
        repeat (4) @(negedge clk);
        if (req_cnt != 32 || res_cnt != 16 || done_cnt != 1) begin
            $display("test%0d: %0d requests, %0d results, %0d done pulses instead of 32, 16, 1",
                     t, req_cnt, res_cnt, done_cnt);
            errors++;
        end
    endtask

    initial begin
        clk            = 1'b0;
        rst_n          = 1'b0;
        start_i        = 1'b0;
        a_base_i       = '0;
        b_base_i       = '0;
        rd_req_ready_i = 1'b0;
        rd_rsp_valid_i = 1'b0;
        rd_rsp_data_i  = '0;
        rd_rsp_id_i    = ID_A;
        res_ready_i    = 1'b0;
        seed           = 39;
        errors         = 0;
        cycle          = 0;
        cur            = 0;
        req_cnt        = 0;
        res_cnt        = 0;
        done_cnt       = 0;
        last_hs        = 0;
        last_due       = 0;
        started        = 1'b0;
        loaded         = 1'b0;
        load_golden();
        if (errors != 0 || num_tests == 0) begin
            $display("golden data could not be loaded, %0d errors", errors);
            $display("ERRORS FOUND");
            $finish;
        end else begin
            fill_memory();
            loaded = 1'b1;
            repeat (3) @(posedge clk);
            @(negedge clk);
            rst_n = 1'b1;
            // outputs must stay quiet over an idle stretch
            repeat (5) @(negedge clk);
            for (int t = 0; t < num_tests; t++)
                run_test(t);
            $display("summary: %0d errors over %0d tests", errors, num_tests);
            if (errors == 0)
                $display("NO ERRORS");
            else
                $display("ERRORS FOUND");
            $finish;
        end
    end

    // budget of 2000 cycles per test
    initial begin
        wait (loaded);
        repeat (num_tests * 2000) @(posedge clk);
        $display("timeout after %0d cycles, test%0d did not finish", cycle, cur);
        $display("summary: %0d errors over %0d tests", errors, num_tests);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule
